// File: mbus_power_pkg.sv
package mbus_power_pkg;

	// ******************************************************************
	// Power control encoding
	// ******************************************************************

	typedef logic [0:0] pwr_ctl_t;

	localparam pwr_ctl_t IO_HOLD    = 1'b0;	// Sleep value.
	localparam pwr_ctl_t IO_RELEASE = 1'b1;	// Awake value.

	// ******************************************************************
	// Sleep controller states
	// ******************************************************************

	typedef enum logic [2:0]
	{
		POS_POWER_UP,	// Switch on, let clock go.
		POS_RELEASE,	// Drop isolation.
		POS_AWAKE,
		POS_ISOLATE,	// Isolation held, power still on.
		POS_ASLEEP
	} sleep_pos_state_t;

	typedef enum logic [1:0]
	{
		NEG_IDLE,
		NEG_RST_RELEASE,
		NEG_AWAKE
	} sleep_neg_state_t;

endpackage

// File: mbus_reg_pkg.sv
package mbus_reg_pkg;

	// ******************************************************************
	// Layer register widths and map
	// ******************************************************************

	localparam int REG_ADDR_W = 4;
	localparam int REG_DATA_W = 8;

	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [REG_DATA_W-1:0] reg_data_t;

	localparam int REG_COUNT = 16;	// Whole address space.

	// Sleep request register.
	localparam reg_addr_t REG_SLEEP = 4'd0;
	localparam int REG_SLEEP_BIT = 0;

endpackage

// File: mbus_power_if.sv
`timescale 1ns/1ps

interface mbus_power_if;

	import mbus_power_pkg::*;

	pwr_ctl_t power_on;
	pwr_ctl_t release_clk;
	pwr_ctl_t release_rst;
	pwr_ctl_t release_iso;

	modport ctrl
	(
		output power_on,
		output release_clk,
		output release_rst,
		output release_iso
	);

	modport gate
	(
		input power_on,
		input release_clk,
		input release_rst,
		input release_iso
	);

endinterface

// File: mbus_regular_sleep_ctrl.sv
`timescale 1ns/1ps

module mbus_regular_sleep_ctrl
(
	input  logic       CLKIN,
	input  logic       RESETn,
	input  logic       sleep_req,
	input  logic       wake_req,
	mbus_power_if.ctrl pwr
);

	import mbus_power_pkg::*;

	sleep_pos_state_t fsm_pos;
	sleep_neg_state_t fsm_neg;

	pwr_ctl_t power_on_pos;
	pwr_ctl_t power_on_neg;
	pwr_ctl_t release_clk_pos;
	pwr_ctl_t release_clk_neg;
	pwr_ctl_t release_rst_pos;
	pwr_ctl_t release_rst_neg;
	pwr_ctl_t release_iso_pos;

	// Either copy holding wins.
	function automatic pwr_ctl_t merge_ctl(input pwr_ctl_t a, input pwr_ctl_t b);
		if ((a == IO_HOLD) || (b == IO_HOLD))
			return IO_HOLD;
		return IO_RELEASE;
	endfunction

	assign pwr.power_on    = merge_ctl(power_on_pos, power_on_neg);
	assign pwr.release_clk = merge_ctl(release_clk_pos, release_clk_neg);
	assign pwr.release_rst = merge_ctl(release_rst_pos, release_rst_neg);
	assign pwr.release_iso = release_iso_pos;	// Only the rising machine isolates.

	// ******************************************************************
	// Rising edge machine
	// ******************************************************************

	always_ff @(posedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
		begin
			fsm_pos <= POS_POWER_UP;
			power_on_pos <= IO_HOLD;
			release_clk_pos <= IO_RELEASE;
			release_rst_pos <= IO_RELEASE;
			release_iso_pos <= IO_HOLD;
		end
		else
		begin
			case (fsm_pos)
				POS_POWER_UP:
				begin
					power_on_pos <= IO_RELEASE;
					release_clk_pos <= IO_RELEASE;
					fsm_pos <= POS_RELEASE;
				end

				POS_RELEASE:
				begin
					release_iso_pos <= IO_RELEASE;
					release_rst_pos <= IO_RELEASE;
					fsm_pos <= POS_AWAKE;
				end

				POS_AWAKE:
				begin
					if (sleep_req)
					begin
						release_iso_pos <= IO_HOLD;	// Isolate first.
						fsm_pos <= POS_ISOLATE;
					end
				end

				POS_ISOLATE:
				begin
					power_on_pos <= IO_HOLD;
					release_clk_pos <= IO_HOLD;
					release_rst_pos <= IO_HOLD;
					fsm_pos <= POS_ASLEEP;
				end

				POS_ASLEEP:
				begin
					if (wake_req)
						fsm_pos <= POS_POWER_UP;
				end

				default:
					fsm_pos <= POS_POWER_UP;
			endcase
		end
	end

	// ******************************************************************
	// Falling edge machine
	// ******************************************************************

	always_ff @(negedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
		begin
			fsm_neg <= NEG_IDLE;
			power_on_neg <= IO_RELEASE;
			release_clk_neg <= IO_HOLD;
			release_rst_neg <= IO_HOLD;
		end
		else
		begin
			case (fsm_neg)
				NEG_IDLE:
				begin
					if (fsm_pos == POS_RELEASE)
					begin
						release_clk_neg <= IO_RELEASE;	// Half cycle after power.
						fsm_neg <= NEG_RST_RELEASE;
					end
					else
					begin
						power_on_neg <= IO_RELEASE;
						release_clk_neg <= IO_HOLD;
						release_rst_neg <= IO_HOLD;
					end
				end

				NEG_RST_RELEASE:
				begin
					release_rst_neg <= IO_RELEASE;
					fsm_neg <= NEG_AWAKE;
				end

				NEG_AWAKE:
				begin
					// Rising copies already hold; keep them held here too.
					if (fsm_pos == POS_ASLEEP)
					begin
						power_on_neg <= IO_HOLD;
						release_clk_neg <= IO_HOLD;
						release_rst_neg <= IO_HOLD;
						fsm_neg <= NEG_IDLE;
					end
				end

				default:
					fsm_neg <= NEG_IDLE;
			endcase
		end
	end

endmodule

// File: mbus_wakeup_detect.sv
`timescale 1ns/1ps

module mbus_wakeup_detect
(
	input  logic       CLKIN,
	input  logic       RESETn,
	input  logic       bus_din,
	mbus_power_if.gate pwr,
	output logic       wake_req
);

	import mbus_power_pkg::*;

	logic [1:0] din_sync;
	logic din_prev;
	logic din_fall;
	logic asleep;

	// Bus idles high.
	always_ff @(posedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
		begin
			din_sync <= 2'b11;
			din_prev <= 1'b1;
		end
		else
		begin
			din_sync <= {din_sync[0], bus_din};
			din_prev <= din_sync[1];
		end
	end

	assign din_fall = din_prev & ~din_sync[1];
	assign asleep = (pwr.power_on == IO_HOLD);

	always_ff @(posedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
			wake_req <= 1'b0;
		else
			wake_req <= din_fall & asleep;	// One cycle wide.
	end

endmodule

// File: mbus_iso_gate.sv
`timescale 1ns/1ps

module mbus_iso_gate
(
	mbus_power_if.gate       pwr,
	input  mbus_reg_pkg::reg_data_t layer_rd_data,
	input  logic             layer_irq,
	output mbus_reg_pkg::reg_data_t bus_rd_data,
	output logic             bus_irq
);

	import mbus_power_pkg::*;

	logic isolated;

	assign isolated = (pwr.release_iso == IO_HOLD);

	// ******************************************************************
	// Output clamps
	// ******************************************************************

	always_comb
	begin
		if (isolated)
		begin
			bus_rd_data = '0;	// Powered down layer reads zero.
			bus_irq = 1'b0;
		end
		else
		begin
			bus_rd_data = layer_rd_data;
			bus_irq = layer_irq;
		end
	end

endmodule

// File: mbus_layer_regs.sv
`timescale 1ns/1ps

module mbus_layer_regs
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic                    CLKIN,
	mbus_power_if.gate              pwr,
	input  logic                    wr_valid,
	input  mbus_reg_pkg::reg_addr_t wr_addr,
	input  mbus_reg_pkg::reg_data_t wr_data,
	output logic                    wr_credit,
	input  mbus_reg_pkg::reg_addr_t rd_addr,
	output mbus_reg_pkg::reg_data_t rd_data,
	output logic                    irq,
	output logic                    sleep_req
);

	import mbus_power_pkg::*;
	import mbus_reg_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic rst_n;
	logic clk_run;
	logic push;
	logic pop;

	reg_addr_t q_addr [QUEUE_DEPTH];
	reg_data_t q_data [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] q_count;
	logic [CNT_W-1:0] credit_due;
	logic [CNT_W:0] credit_sum;

	reg_data_t regs [REG_COUNT];

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign rst_n = (pwr.release_rst == IO_RELEASE);
	assign clk_run = (pwr.release_clk == IO_RELEASE);

	assign push = wr_valid & clk_run;	// Sender only writes with a credit.
	assign pop = (q_count != '0) & clk_run;

	assign credit_sum = {1'b0, credit_due} + {{CNT_W{1'b0}}, pop};

	// ******************************************************************
	// Write queue and credit return
	// ******************************************************************

	always_ff @(posedge CLKIN)
	begin
		if (push)
		begin
			q_addr[wr_ptr] <= wr_addr;
			q_data[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge CLKIN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
			credit_due <= CNT_W'(QUEUE_DEPTH);	// Initial credit burst.
			wr_credit <= 1'b0;
		end
		else if (clk_run)
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10: q_count <= q_count + 1'b1;
				2'b01: q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
			if (credit_sum != '0)
			begin
				wr_credit <= 1'b1;
				credit_due <= CNT_W'(credit_sum - 1'b1);
			end
			else
			begin
				wr_credit <= 1'b0;
				credit_due <= '0;
			end
		end
	end

	// ******************************************************************
	// Register array
	// ******************************************************************

	always_ff @(posedge CLKIN or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
			irq <= 1'b0;
			sleep_req <= 1'b0;
		end
		else if (clk_run)
		begin
			if (pop)
			begin
				regs[q_addr[rd_ptr]] <= q_data[rd_ptr];
				if (q_addr[rd_ptr] != REG_SLEEP)
					irq <= (q_data[rd_ptr] != '0);
			end
			sleep_req <= regs[REG_SLEEP][REG_SLEEP_BIT];	// One cycle after retire.
		end
	end

	assign rd_data = regs[rd_addr];

endmodule

// File: mbus_power_top.sv
`timescale 1ns/1ps

module mbus_power_top
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic                      CLKIN,
	input  logic                      RESETn,
	input  logic                      bus_din,
	input  logic                      wr_valid,
	input  mbus_reg_pkg::reg_addr_t   wr_addr,
	input  mbus_reg_pkg::reg_data_t   wr_data,
	output logic                      wr_credit,
	input  mbus_reg_pkg::reg_addr_t   rd_addr,
	output mbus_reg_pkg::reg_data_t   rd_data,
	output logic                      irq,
	output mbus_power_pkg::pwr_ctl_t  power_on,
	output mbus_power_pkg::pwr_ctl_t  release_clk,
	output mbus_power_pkg::pwr_ctl_t  release_rst,
	output mbus_power_pkg::pwr_ctl_t  release_iso
);

	import mbus_reg_pkg::*;

	logic wake_req;
	logic sleep_req;
	reg_data_t layer_rd_data;
	logic layer_irq;

	mbus_power_if pwr_if ();

	// ******************************************************************
	// Always-on blocks
	// ******************************************************************

	mbus_regular_sleep_ctrl sleep_ctrl_i (
		.CLKIN     (CLKIN),
		.RESETn    (RESETn),
		.sleep_req (sleep_req),
		.wake_req  (wake_req),
		.pwr       (pwr_if.ctrl)
	);

	mbus_wakeup_detect wakeup_i (
		.CLKIN    (CLKIN),
		.RESETn   (RESETn),
		.bus_din  (bus_din),
		.pwr      (pwr_if.gate),
		.wake_req (wake_req)
	);

	mbus_iso_gate iso_i (
		.pwr           (pwr_if.gate),
		.layer_rd_data (layer_rd_data),
		.layer_irq     (layer_irq),
		.bus_rd_data   (rd_data),
		.bus_irq       (irq)
	);

	// Switched domain.
	mbus_layer_regs #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) regs_i (
		.CLKIN     (CLKIN),
		.pwr       (pwr_if.gate),
		.wr_valid  (wr_valid),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_credit (wr_credit),
		.rd_addr   (rd_addr),
		.rd_data   (layer_rd_data),
		.irq       (layer_irq),
		.sleep_req (sleep_req)
	);

	assign power_on    = pwr_if.power_on;
	assign release_clk = pwr_if.release_clk;
	assign release_rst = pwr_if.release_rst;
	assign release_iso = pwr_if.release_iso;

endmodule

// File: tb_mbus_power.sv
`timescale 1ns/1ps

module tb_mbus_power;

	import mbus_power_pkg::*;
	import mbus_reg_pkg::*;

	localparam int QUEUE_DEPTH = 4;
	localparam int NUM_WRITES = 24;
	localparam int POLL_LIMIT = 16;	// Longest wait for a power step.

	// Power-ups and sleep, credit bursts, random writes, three read passes.
	localparam int TEST_CYCLES = 3 + 3 * POLL_LIMIT + 3 * (QUEUE_DEPTH + 8)
		+ 4 * NUM_WRITES + 3 * REG_COUNT + 20;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 100;

	logic CLKIN;
	logic RESETn;
	logic bus_din;
	logic wr_valid;
	reg_addr_t wr_addr;
	reg_data_t wr_data;
	logic wr_credit;
	reg_addr_t rd_addr;
	reg_data_t rd_data;
	logic irq;
	pwr_ctl_t power_on;
	pwr_ctl_t release_clk;
	pwr_ctl_t release_rst;
	pwr_ctl_t release_iso;

	int value_errors;
	int other_errors;
	int credits;	// Held by the sender.
	int credit_pulses;
	reg_data_t shadow [REG_COUNT];
	logic exp_irq;

	mbus_power_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) dut_i (
		.CLKIN       (CLKIN),
		.RESETn      (RESETn),
		.bus_din     (bus_din),
		.wr_valid    (wr_valid),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.wr_credit   (wr_credit),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.irq         (irq),
		.power_on    (power_on),
		.release_clk (release_clk),
		.release_rst (release_rst),
		.release_iso (release_iso)
	);

	always #4 CLKIN = ~CLKIN;

	// ******************************************************************
	// Concurrent checks
	// ******************************************************************

	clamp_check: assert property (@(posedge CLKIN) disable iff (!RESETn)
		(release_iso == IO_HOLD) |-> (rd_data == '0 && irq == 1'b0))
	else
	begin
		value_errors++;
		$display("Fail iso clamp: expected 0, actual %0h", {irq, rd_data});
	end

	order_check: assert property (@(posedge CLKIN) disable iff (!RESETn)
		(release_iso == IO_RELEASE) |->
		(power_on == IO_RELEASE && release_clk == IO_RELEASE && release_rst == IO_RELEASE))
	else
	begin
		other_errors++;
		$display("Isolation was released while another power control still held");
	end

	clk_check: assert property (@(posedge CLKIN) disable iff (!RESETn)
		(release_clk == IO_RELEASE) |-> (power_on == IO_RELEASE))
	else
	begin
		other_errors++;
		$display("Clock was released while the power switch was off");
	end

	credit_check: assert property (@(posedge CLKIN) disable iff (!RESETn)
		(release_rst == IO_HOLD) |-> !wr_credit)
	else
	begin
		other_errors++;
		$display("A credit was returned while the layer was held in reset");
	end

	// ******************************************************************
	// Helper tasks
	// ******************************************************************

	task automatic next_cycle();
		@(posedge CLKIN);
		if (wr_credit)
		begin
			credits++;
			credit_pulses++;
		end
		assert (credits <= QUEUE_DEPTH)
		else
		begin
			other_errors++;
			$display("Sender holds %0d credits, more than the queue depth", credits);
		end
	endtask

	task automatic compare(input string name, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			value_errors++;
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic send_write(input reg_addr_t addr, input reg_data_t data);
		if (credits == 0)
		begin
			other_errors++;
			$display("Write to register %0d attempted without a credit", addr);
		end
		else
		begin
			credits--;
			wr_valid <= 1'b1;
			wr_addr <= addr;
			wr_data <= data;
		end
	endtask

	task automatic read_back(input reg_addr_t addr, input reg_data_t expected, input string name);
		next_cycle();
		rd_addr <= addr;
		@(negedge CLKIN);
		compare($sformatf("%s reg %0d", name, addr), expected, rd_data);
	endtask

	// Controls listed as power_on, release_clk, release_rst, release_iso.
	task automatic power_up_order(input string name, output int waited);
		waited = 0;
		while ((power_on == IO_HOLD) && (waited < POLL_LIMIT))
		begin
			next_cycle();
			#1;
			waited++;
		end
		if (power_on == IO_HOLD)
		begin
			other_errors++;
			$display("%s: power switch not released within %0d cycles", name, POLL_LIMIT);
		end
		else
		begin
			compare({name, " step 1"}, {IO_RELEASE, IO_HOLD, IO_HOLD, IO_HOLD},
				{power_on, release_clk, release_rst, release_iso});
			@(negedge CLKIN);
			#1;
			compare({name, " step 2"}, {IO_RELEASE, IO_RELEASE, IO_HOLD, IO_HOLD},
				{power_on, release_clk, release_rst, release_iso});
			next_cycle();
			#1;
			compare({name, " step 3"}, {IO_RELEASE, IO_RELEASE, IO_HOLD, IO_RELEASE},
				{power_on, release_clk, release_rst, release_iso});
			@(negedge CLKIN);
			#1;
			compare({name, " step 4"}, {IO_RELEASE, IO_RELEASE, IO_RELEASE, IO_RELEASE},
				{power_on, release_clk, release_rst, release_iso});
		end
	endtask

	task automatic enter_sleep();
		int waited;
		next_cycle();
		send_write(REG_SLEEP, 8'h01);
		next_cycle();
		wr_valid <= 1'b0;
		waited = 0;
		while ((release_iso == IO_RELEASE) && (waited < POLL_LIMIT))
		begin
			next_cycle();
			#1;
			waited++;
		end
		if (release_iso == IO_RELEASE)
		begin
			other_errors++;
			$display("Isolation not held within %0d cycles of the sleep write", POLL_LIMIT);
		end
		else
		begin
			compare("sleep isolate", {IO_RELEASE, IO_RELEASE, IO_RELEASE, IO_HOLD},
				{power_on, release_clk, release_rst, release_iso});
			next_cycle();
			#1;
			compare("sleep power down", {IO_HOLD, IO_HOLD, IO_HOLD, IO_HOLD},
				{power_on, release_clk, release_rst, release_iso});
			credits = 0;	// Queue and credits are gone.
		end
	endtask

	task automatic pulse_bus_low();
		next_cycle();
		bus_din <= 1'b0;
		next_cycle();
		next_cycle();
		bus_din <= 1'b1;
	endtask

	// ******************************************************************
	// Test sequence
	// ******************************************************************

	initial
	begin
		int waited;
		int accepted;
		reg_addr_t addr;
		reg_data_t data;

		void'($urandom(48));
		CLKIN = 1'b0;
		RESETn = 1'b0;
		bus_din = 1'b1;	// Bus idles high.
		wr_valid = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rd_addr = '0;
		value_errors = 0;
		other_errors = 0;
		credits = 0;
		credit_pulses = 0;
		exp_irq = 1'b0;
		accepted = 0;
		foreach (shadow[i])
			shadow[i] = '0;

		repeat (3) next_cycle();
		RESETn <= 1'b1;
		power_up_order("reset", waited);
		compare("reset power_on edge", 1, waited);
		repeat (QUEUE_DEPTH + 8) next_cycle();
		compare("reset credit burst", QUEUE_DEPTH, credit_pulses);

		while (accepted < NUM_WRITES)
		begin
			next_cycle();
			if ((credits > 0) && (($urandom % 4) != 0))
			begin
				addr = reg_addr_t'($urandom % REG_COUNT);
				data = reg_data_t'($urandom);
				if (($urandom % 4) == 0)
					data = '0;
				if (addr == REG_SLEEP)
					data[REG_SLEEP_BIT] = 1'b0;	// Stay awake.
				else
					exp_irq = (data != '0);
				shadow[addr] = data;
				send_write(addr, data);
				accepted++;
			end
			else
				wr_valid <= 1'b0;
		end
		next_cycle();
		wr_valid <= 1'b0;
		repeat (QUEUE_DEPTH + 8) next_cycle();
		compare("write credits held", QUEUE_DEPTH, credits);
		compare("write credit pulses", QUEUE_DEPTH + NUM_WRITES, credit_pulses);
		for (int i = 0; i < REG_COUNT; i++)
			read_back(reg_addr_t'(i), shadow[i], "readback");
		compare("irq after writes", exp_irq, irq);

		enter_sleep();
		for (int i = 0; i < REG_COUNT; i++)
			read_back(reg_addr_t'(i), '0, "sleep read");
		compare("sleep irq", 0, irq);
		compare("sleep credits", 0, credits);

		pulse_bus_low();
		power_up_order("wake", waited);
		repeat (QUEUE_DEPTH + 8) next_cycle();
		compare("wake credit burst", QUEUE_DEPTH, credits);
		for (int i = 0; i < REG_COUNT; i++)
			read_back(reg_addr_t'(i), '0, "wake read");
		compare("wake irq", 0, irq);

		// Bus activity while awake is ignored.
		pulse_bus_low();
		repeat (6)
		begin
			next_cycle();
			#1;
			compare("awake bus edge", {IO_RELEASE, IO_RELEASE, IO_RELEASE, IO_RELEASE},
				{power_on, release_clk, release_rst, release_iso});
		end

		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if ((value_errors + other_errors) == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge CLKIN);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: vlog.f
mbus_power_pkg.sv
mbus_reg_pkg.sv
mbus_power_if.sv
mbus_regular_sleep_ctrl.sv
mbus_wakeup_detect.sv
mbus_iso_gate.sv
mbus_layer_regs.sv
mbus_power_top.sv
tb_mbus_power.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mbus_power -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0
